/* frogger_hazard_top.f */
+incdir+hdl
hdl/frogger_hazard_pkg.sv
hdl/lane_span_check.sv
hdl/hazard_verdict.sv
hdl/frogger_hazard_top.sv
verification/tb_clock_gen.sv
verification/frogger_hazard_props.sv
verification/frogger_hazard_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the frogger hazard testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module frogger_hazard_tb \
    -f frogger_hazard_top.f \
    -o frogger_hazard_sim
if [ $? -ne 0 ]; then
    echo "run_sim: build failed"
    exit 1
fi

output=$(./obj_dir/frogger_hazard_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Done: no errors"; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1

/* verification/frogger_hazard_tb.sv */
`timescale 1ns/1ns
`include "frogger_settings.svh"

module frogger_hazard_tb
    import frogger_hazard_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int N_ROAD       = 300;
    localparam int N_RIVER      = 300;
    localparam int N_BOUND      = 200;
    localparam int N_STREAM     = 400;
    localparam int N_RESET      = 40;
    localparam int TOTAL        = N_ROAD + N_RIVER + N_BOUND + N_STREAM + N_RESET;
    localparam int LIMIT_CYCLES = TOTAL * 3 + 200;

    typedef struct packed {
        hazard_verdict_t v;
        int unsigned     due;
    } expect_t;

    logic            osc_25_1M;
    logic            rst_n;
    logic            frame_valid;
    frog_pos_t       frog;
    car_lane_t       road_lanes  [`NUM_LANES];
    log_lane_t       river_lanes [`NUM_LANES];
    logic            verdict_valid;
    hazard_verdict_t verdict;

    expect_t     pending [$];
    int unsigned cycle;
    int          errors;
    int          checked;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clock_gen (.osc_25_1M(osc_25_1M));

    frogger_hazard_top i_frogger_hazard_top (
        .osc_25_1M     (osc_25_1M),
        .rst_n         (rst_n),
        .frame_valid   (frame_valid),
        .frog          (frog),
        .road_lanes    (road_lanes),
        .river_lanes   (river_lanes),
        .verdict_valid (verdict_valid),
        .verdict       (verdict)
    );

    // overlap of frog and one object in grid row `row`
    function automatic bit touches(input int fx, input int fy, input int ox, input int len,
                                   input int row);
        int top;
        top = row * `BLOCK_SIZE;
        return (fx < ox + len) && (fx + `FROG_SIZE > ox) &&
               (fy < top + `BLOCK_SIZE) && (fy + `FROG_SIZE > top);
    endfunction

    function automatic hazard_verdict_t expected_verdict();
        hazard_verdict_t v;
        int              fx;
        int              fy;
        v  = '0;
        fx = int'(frog.x);
        fy = int'(frog.y);
        for (int l = 0; l < `NUM_LANES; l++) begin
            for (int s = 0; s < `MAX_CARS; s++) begin
                if (s < int'(road_lanes[l].count) &&
                    touches(fx, fy, int'(road_lanes[l].left_x[s]), int'(road_lanes[l].len),
                            `ROAD_FIRST_ROW + l)) begin
                    v.car_hit = 1'b1;
                end
            end
            for (int s = 0; s < `MAX_LOGS; s++) begin
                if (s < int'(river_lanes[l].count) &&
                    touches(fx, fy, int'(river_lanes[l].left_x[s]), int'(river_lanes[l].len),
                            `RIVER_FIRST_ROW + l)) begin
                    // first lane found is the lowest
                    if (!v.on_log) begin
                        v.ride_lane = 3'(l);
                    end
                    v.on_log = 1'b1;
                end
            end
        end
        v.in_water    = (fy >= `RIVER_TOP) && (fy < `RIVER_BOTTOM) && !v.on_log;
        v.off_screen  = (fx + `FROG_SIZE <= `FIELD_LEFT) || (fx >= `FIELD_RIGHT);
        v.reached_end = fy < `BLOCK_SIZE;
        v.collision   = v.car_hit || v.in_water || v.off_screen;
        return v;
    endfunction

    // left edge close to the frog half the time
    function automatic coord_t object_x(input int fx);
        int ox;
        if ($urandom_range(1, 0) == 0) begin
            ox = int'($urandom_range(640, 0));
        end else begin
            ox = fx + int'($urandom_range(170, 0)) - 130;
        end
        if (ox < 0) begin
            ox = 0;
        end
        return coord_t'(ox);
    endfunction

    // mode 0 road, 1 river, 2 field edges, 3 any of these
    task automatic randomize_snapshot(input int mode);
        int fx;
        int fy;
        int m;
        m = (mode == 3) ? int'($urandom_range(2, 0)) : mode;
        case (m)
            0: fy = (`ROAD_FIRST_ROW + int'($urandom_range(5, 0))) * `BLOCK_SIZE +
                    int'($urandom_range(40, 0)) - 20;
            1: fy = (`RIVER_FIRST_ROW + int'($urandom_range(5, 0))) * `BLOCK_SIZE +
                    int'($urandom_range(40, 0)) - 20;
            default: fy = ($urandom_range(1, 0) == 0) ? int'($urandom_range(31, 0)) :
                                                        int'($urandom_range(479, 0));
        endcase
        if (m == 2) begin
            fx = ($urandom_range(1, 0) == 0) ? `FIELD_LEFT - `FROG_SIZE : `FIELD_RIGHT;
            fx = fx + int'($urandom_range(16, 0)) - 8;
        end else begin
            fx = int'($urandom_range(600, 40));
        end
        frog.x = coord_t'(fx);
        frog.y = coord_t'(fy);
        for (int l = 0; l < `NUM_LANES; l++) begin
            road_lanes[l].len    = coord_t'($urandom_range(128, 24));
            road_lanes[l].count  = 2'($urandom_range(3, 0));
            river_lanes[l].len   = coord_t'($urandom_range(128, 24));
            river_lanes[l].count = 2'($urandom_range(3, 0));
            for (int s = 0; s < `MAX_CARS; s++) begin
                road_lanes[l].left_x[s] = object_x(fx);
            end
            for (int s = 0; s < `MAX_LOGS; s++) begin
                river_lanes[l].left_x[s] = object_x(fx);
            end
        end
    endtask

    task automatic compare_field(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_verdict();
        expect_t e;
        if (verdict_valid) begin
            if (pending.size() == 0) begin
                $display("Error at %0t: verdict came out with no snapshot pending", $time);
                errors++;
            end else begin
                e = pending.pop_front();
                if (e.due != cycle) begin
                    $display("Error at %0t: verdict in cycle %0d, expected in cycle %0d",
                             $time, cycle, e.due);
                    errors++;
                end
                compare_field("car_hit", int'(verdict.car_hit), int'(e.v.car_hit));
                compare_field("in_water", int'(verdict.in_water), int'(e.v.in_water));
                compare_field("off_screen", int'(verdict.off_screen), int'(e.v.off_screen));
                compare_field("collision", int'(verdict.collision), int'(e.v.collision));
                compare_field("reached_end", int'(verdict.reached_end), int'(e.v.reached_end));
                compare_field("on_log", int'(verdict.on_log), int'(e.v.on_log));
                compare_field("ride_lane", int'(verdict.ride_lane), int'(e.v.ride_lane));
                checked++;
            end
        end else if (pending.size() > 0 && pending[0].due <= cycle) begin
            $display("Error at %0t: no verdict for the snapshot due in cycle %0d",
                     $time, pending[0].due);
            errors++;
            e = pending.pop_front();
        end
    endtask

    // outputs are checked on the falling edge, before new inputs go out
    task automatic next_cycle();
        @(negedge osc_25_1M);
        cycle++;
        check_verdict();
    endtask

    task automatic send_snapshot(input int mode);
        expect_t e;
        randomize_snapshot(mode);
        frame_valid = 1'b1;
        e.v   = expected_verdict();
        e.due = cycle + 2;
        pending.push_back(e);
    endtask

    task automatic drain();
        repeat (4) begin
            next_cycle();
            frame_valid = 1'b0;
        end
    endtask

    task automatic run_burst(input string name, input int mode, input int count,
                             input int max_gap);
        int start_errors;
        start_errors = errors;
        for (int i = 0; i < count; i++) begin
            next_cycle();
            send_snapshot(mode);
            repeat ($urandom_range(max_gap, 0)) begin
                next_cycle();
                frame_valid = 1'b0;
            end
        end
        drain();
        $display("%s: %0d snapshots, %0d errors", name, count, errors - start_errors);
    endtask

    // reset lands in the middle of a back to back burst
    task automatic run_reset_test();
        int start_errors;
        start_errors = errors;
        for (int i = 0; i < N_RESET; i++) begin
            next_cycle();
            if (i == 15) begin
                rst_n = 1'b0;
                pending.delete();
            end
            if (i == 20) begin
                rst_n = 1'b1;
            end
            if (rst_n) begin
                send_snapshot(3);
            end else begin
                randomize_snapshot(3);
                frame_valid = 1'b1;
            end
        end
        drain();
        $display("reset: %0d snapshots, %0d errors", N_RESET, errors - start_errors);
    endtask

    initial begin
        void'($urandom(24378));
        rst_n       = 1'b0;
        frame_valid = 1'b0;
        frog        = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            road_lanes[l]  = '0;
            river_lanes[l] = '0;
        end
        cycle   = 0;
        errors  = 0;
        checked = 0;
        repeat (5) begin
            next_cycle();
        end
        rst_n = 1'b1;
        run_burst("road hits", 0, N_ROAD, 0);
        run_burst("river", 1, N_RIVER, 0);
        run_burst("field bounds", 2, N_BOUND, 0);
        run_burst("streaming", 3, N_STREAM, 2);
        run_reset_test();
        $display("verdicts checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the snapshot count
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: run went past %0d cycles", LIMIT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* verification/frogger_hazard_props.sv */
`timescale 1ns/1ns

module frogger_hazard_props
    import frogger_hazard_pkg::*;
(
    input logic            osc_25_1M,
    input logic            rst_n,
    input logic            frame_valid,
    input logic            verdict_valid,
    input hazard_verdict_t verdict
);

    // two cycle latency, a reset on either cycle drops the frame
    a_latency: assert property (
        @(posedge osc_25_1M) disable iff (!rst_n)
        verdict_valid == ($past(frame_valid, 2) && $past(rst_n, 2) && $past(rst_n, 1))
    ) else $error("verdict_valid out of step with frame_valid");

    a_collision: assert property (
        @(posedge osc_25_1M) disable iff (!rst_n)
        verdict_valid |->
            verdict.collision == (verdict.car_hit || verdict.in_water || verdict.off_screen)
    ) else $error("collision is not the OR of its causes");

    // riding a log means the frog is not in the water
    a_water_log: assert property (
        @(posedge osc_25_1M) disable iff (!rst_n)
        verdict_valid |-> !(verdict.in_water && verdict.on_log)
    ) else $error("in_water and on_log set together");

endmodule

bind hazard_verdict frogger_hazard_props verdict_props (
    .osc_25_1M     (osc_25_1M),
    .rst_n         (rst_n),
    .frame_valid   (frame_valid),
    .verdict_valid (verdict_valid),
    .verdict       (verdict)
);

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic osc_25_1M
);

    initial begin
        osc_25_1M = 1'b0;
        forever begin
            #(PERIOD_NS / 2) osc_25_1M = ~osc_25_1M;
        end
    end

endmodule

/* hdl/frogger_hazard_top.sv */
`timescale 1ns/1ns
`include "frogger_settings.svh"

module frogger_hazard_top
    import frogger_hazard_pkg::*;
(
    input  logic            osc_25_1M,
    input  logic            rst_n,
    input  logic            frame_valid,
    input  frog_pos_t       frog,
    input  car_lane_t       road_lanes  [`NUM_LANES],
    input  log_lane_t       river_lanes [`NUM_LANES],
    output logic            verdict_valid,
    output hazard_verdict_t verdict
);

    logic       road_hits_valid;
    lane_hits_t road_hits;
    lane_hits_t river_hits;

    // road lanes, two car slots each
    lane_span_check #(
        .lane_t    (car_lane_t),
        .FIRST_ROW (`ROAD_FIRST_ROW),
        .SLOTS     (`MAX_CARS)
    ) road_scan (
        .osc_25_1M   (osc_25_1M),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frog        (frog),
        .lanes       (road_lanes),
        .hits_valid  (road_hits_valid),
        .hits        (road_hits)
    );

    // river lanes, valid matches the road scanner
    lane_span_check #(
        .lane_t    (log_lane_t),
        .FIRST_ROW (`RIVER_FIRST_ROW),
        .SLOTS     (`MAX_LOGS)
    ) river_scan (
        .osc_25_1M   (osc_25_1M),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frog        (frog),
        .lanes       (river_lanes),
        .hits_valid  (),
        .hits        (river_hits)
    );

    hazard_verdict verdict_stage (
        .osc_25_1M     (osc_25_1M),
        .rst_n         (rst_n),
        .frame_valid   (frame_valid),
        .frog          (frog),
        .hits_valid    (road_hits_valid),
        .road_hits     (road_hits),
        .river_hits    (river_hits),
        .verdict_valid (verdict_valid),
        .verdict       (verdict)
    );

endmodule

/* hdl/hazard_verdict.sv */
`timescale 1ns/1ns
`include "frogger_settings.svh"

module hazard_verdict
    import frogger_hazard_pkg::*;
(
    input  logic            osc_25_1M,
    input  logic            rst_n,
    input  logic            frame_valid,
    input  frog_pos_t       frog,
    input  logic            hits_valid,
    input  lane_hits_t      road_hits,
    input  lane_hits_t      river_hits,
    output logic            verdict_valid,
    output hazard_verdict_t verdict
);

    typedef struct packed {
        logic off_screen;
        logic in_river_rows;
        logic reached_end;
    } bounds_t;

    bounds_t         bounds_next;
    bounds_t         bounds_q;
    hazard_verdict_t verdict_next;

    // field bounds straight from the frog position
    always_comb begin
        bounds_next.off_screen    = ({1'b0, frog.x} + (`COORD_W+1)'(`FROG_SIZE) <=
                                     (`COORD_W+1)'(`FIELD_LEFT)) ||
                                    (frog.x >= `COORD_W'(`FIELD_RIGHT));
        bounds_next.in_river_rows = (frog.y >= `COORD_W'(`RIVER_TOP)) &&
                                    (frog.y < `COORD_W'(`RIVER_BOTTOM));
        bounds_next.reached_end   = frog.y < `COORD_W'(`BLOCK_SIZE);
    end

    // stage 1 register in step with the scanner registers
    always_ff @(posedge osc_25_1M) begin
        if (frame_valid) begin
            bounds_q <= bounds_next;
        end
    end

    always_comb begin
        verdict_next             = '0;
        verdict_next.car_hit     = |road_hits;
        verdict_next.on_log      = |river_hits;
        verdict_next.in_water    = bounds_q.in_river_rows && !(|river_hits);
        verdict_next.off_screen  = bounds_q.off_screen;
        verdict_next.reached_end = bounds_q.reached_end;
        verdict_next.collision   = verdict_next.car_hit || verdict_next.in_water ||
                                   bounds_q.off_screen;
        // walk down so the lowest hit lane wins
        for (int l = `NUM_LANES - 1; l >= 0; l--) begin
            if (river_hits[l]) begin
                verdict_next.ride_lane = 3'(l);
            end
        end
    end

    always_ff @(posedge osc_25_1M) begin
        if (!rst_n) begin
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= hits_valid;
        end
    end

    always_ff @(posedge osc_25_1M) begin
        if (hits_valid) begin
            verdict <= verdict_next;
        end
    end

endmodule

/* hdl/lane_span_check.sv */
`timescale 1ns/1ns
`include "frogger_settings.svh"

module lane_span_check
    import frogger_hazard_pkg::*;
#(
    parameter type lane_t    = car_lane_t,
    parameter int  FIRST_ROW = `ROAD_FIRST_ROW,
    parameter int  SLOTS     = `MAX_CARS
) (
    input  logic       osc_25_1M,
    input  logic       rst_n,
    input  logic       frame_valid,
    input  frog_pos_t  frog,
    input  lane_t      lanes [`NUM_LANES],
    output logic       hits_valid,
    output lane_hits_t hits
);

    // one extra bit so edge sums never wrap
    localparam int W = `COORD_W + 1;

    lane_hits_t hits_next;

    // horizontal span test for a single object
    function automatic logic x_overlap(coord_t fx, coord_t ox, coord_t len);
        logic [W-1:0] fx_w;
        logic [W-1:0] ox_w;
        fx_w = {1'b0, fx};
        ox_w = {1'b0, ox};
        return (fx_w < ox_w + {1'b0, len}) && (fx_w + W'(`FROG_SIZE) > ox_w);
    endfunction

    always_comb begin
        logic [W-1:0] lane_top;
        logic [W-1:0] fy_w;
        logic         row_hit;
        hits_next = '0;
        fy_w      = {1'b0, frog.y};
        for (int l = 0; l < `NUM_LANES; l++) begin
            lane_top = W'((FIRST_ROW + l) * `BLOCK_SIZE);
            // vertical test is the same for every slot in the lane
            row_hit = (fy_w < lane_top + W'(`BLOCK_SIZE)) &&
                      (fy_w + W'(`FROG_SIZE) > lane_top);
            for (int s = 0; s < SLOTS; s++) begin
                // slots at or above count are idle
                if (row_hit && (s < lanes[l].count) &&
                    x_overlap(frog.x, lanes[l].left_x[s], lanes[l].len)) begin
                    hits_next[l] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge osc_25_1M) begin
        if (!rst_n) begin
            hits_valid <= 1'b0;
        end else begin
            hits_valid <= frame_valid;
        end
    end

    // hit vector only moves with a new snapshot
    always_ff @(posedge osc_25_1M) begin
        if (frame_valid) begin
            hits <= hits_next;
        end
    end

endmodule

/* hdl/frogger_hazard_pkg.sv */
`include "frogger_settings.svh"

package frogger_hazard_pkg;

    typedef logic [`COORD_W-1:0] coord_t;

    // one road lane, all cars in a lane share a length
    typedef struct packed {
        coord_t [`MAX_CARS-1:0] left_x;
        coord_t                 len;
        logic   [1:0]           count;
    } car_lane_t;

    // one river lane, same layout with more slots
    typedef struct packed {
        coord_t [`MAX_LOGS-1:0] left_x;
        coord_t                 len;
        logic   [1:0]           count;
    } log_lane_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } frog_pos_t;

    // bit n set when the frog touches an object in lane n
    typedef logic [`NUM_LANES-1:0] lane_hits_t;

    typedef struct packed {
        logic       car_hit;
        logic       in_water;
        logic       off_screen;
        logic       collision;
        logic       reached_end;
        logic       on_log;
        logic [2:0] ride_lane;
    } hazard_verdict_t;

endpackage

/* hdl/frogger_settings.svh */
`ifndef FROGGER_SETTINGS_SVH
`define FROGGER_SETTINGS_SVH

// pixel coordinates
`define COORD_W         10

// grid geometry
`define BLOCK_SIZE      32
`define FROG_SIZE       32

// horizontal play field bounds
`define FIELD_LEFT      96
`define FIELD_RIGHT     576

// river rows, top inclusive, bottom exclusive
`define RIVER_TOP       32
`define RIVER_BOTTOM    224

// grid row of lane 0 in each group
`define ROAD_FIRST_ROW  8
`define RIVER_FIRST_ROW 1

// lane and object limits
`define NUM_LANES       6
`define MAX_CARS        2
`define MAX_LOGS        3

`endif
